//--- project.f
src/pcie_dllp_pkg.sv
src/pcie_datalink_pkg.sv
src/pcie_datalink_init.sv
src/dllp_receive.sv
src/dllp_transmit.sv
src/phy_tx_arbiter.sv
src/pcie_datalink_layer.sv
verif/pcie_datalink_layer_props.sv
verif/pcie_datalink_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
  --top-module pcie_datalink_layer_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^\*\*\* TEST PASSED \*\*\*$'; then
  exit 0
fi
exit 1

//--- src/dllp_receive.sv
`timescale 1ns/10ps

module dllp_receive
  import pcie_dllp_pkg::*;
  import pcie_datalink_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             soft_reset_i,
  input  pcie_dl_status_e  link_status_i,
  input  logic [31:0]      s_axis_tdata_i,
  input  logic             s_axis_tvalid_i,
  input  logic             s_axis_tlast_i,
  output logic             s_axis_tready_o,
  output logic [31:0]      m_axis_tdata_o,
  output logic             m_axis_tvalid_o,
  output logic             m_axis_tlast_o,
  input  logic             m_axis_tready_i,
  output logic             rx_initfc1_o,
  output logic             rx_initfc2_o,
  output logic             rx_ack_vld_o,
  output logic [SEQ_W-1:0] rx_ack_seq_o,
  output logic             ack_req_o,
  output dllp_req_e        ack_req_type_o,
  output logic [SEQ_W-1:0] ack_req_seq_o
);

  typedef enum logic [1:0] {IDLE, FORWARD, DROP} parse_state_e;

  parse_state_e     pstate;
  logic [SEQ_W-1:0] expected_seq;
  logic             nak_pending;
  dllp_type_e       rx_type;
  logic [SEQ_W-1:0] rx_seq;
  logic             link_active;
  logic             fwd_ok;
  logic             beat_done;

  assign rx_type     = dllp_type_e'(s_axis_tdata_i[TYPE_LSB +: TYPE_W]);
  assign rx_seq      = s_axis_tdata_i[SEQ_W-1:0];
  assign link_active = (link_status_i == DL_ACTIVE);
  assign fwd_ok      = (pstate == FORWARD) && link_active;

  // Headers, DLLPs and dropped payload are always taken
  assign s_axis_tready_o = fwd_ok ? m_axis_tready_i : 1'b1;
  assign beat_done       = s_axis_tvalid_i && s_axis_tready_o;

  assign m_axis_tdata_o  = s_axis_tdata_i;
  assign m_axis_tvalid_o = fwd_ok && s_axis_tvalid_i;
  assign m_axis_tlast_o  = s_axis_tlast_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || soft_reset_i) begin
      pstate       <= IDLE;
      expected_seq <= '0;
      nak_pending  <= 1'b0;
      rx_initfc1_o <= 1'b0;
      rx_initfc2_o <= 1'b0;
      rx_ack_vld_o <= 1'b0;
      ack_req_o    <= 1'b0;
    end else begin
      rx_initfc1_o <= 1'b0;
      rx_initfc2_o <= 1'b0;
      rx_ack_vld_o <= 1'b0;
      ack_req_o    <= 1'b0;
      if (beat_done) begin
        case (pstate)
          IDLE: begin
            rx_initfc1_o <= (rx_type == DLLP_INITFC1);
            rx_initfc2_o <= (rx_type == DLLP_INITFC2);
            rx_ack_vld_o <= (rx_type == DLLP_ACK) || (rx_type == DLLP_NAK);
            if (rx_type == PKT_TLP_HDR) begin
              // Outside DL_ACTIVE the packet is dropped silently
              nak_pending <= link_active && (rx_seq != expected_seq);
              if (link_active && (rx_seq == expected_seq)) begin
                pstate <= FORWARD;
              end else begin
                pstate <= DROP;
              end
            end
          end
          FORWARD: begin
            if (s_axis_tlast_i) begin
              pstate <= IDLE;
              if (link_active) begin
                expected_seq <= expected_seq + SEQ_W'(1);
                ack_req_o    <= 1'b1;
              end
            end
          end
          default: begin
            if (s_axis_tlast_i) begin
              pstate    <= IDLE;
              ack_req_o <= nak_pending;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_done && (pstate == IDLE)) begin
      rx_ack_seq_o <= rx_seq;
    end
    if (beat_done && s_axis_tlast_i) begin
      if (pstate == FORWARD) begin
        ack_req_type_o <= REQ_ACK;
        ack_req_seq_o  <= expected_seq;
      end else if (pstate == DROP) begin
        // Nak names the last good sequence number
        ack_req_type_o <= REQ_NAK;
        ack_req_seq_o  <= expected_seq - SEQ_W'(1);
      end
    end
  end

endmodule

//--- src/dllp_transmit.sv
`timescale 1ns/10ps

module dllp_transmit
  import pcie_dllp_pkg::*;
  import pcie_datalink_pkg::*;
#(
  parameter int RETRY_TLP_SIZE = 3
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             soft_reset_i,
  input  pcie_dl_status_e  link_status_i,
  input  logic [31:0]      s_axis_tdata_i,
  input  logic             s_axis_tvalid_i,
  input  logic             s_axis_tlast_i,
  output logic             s_axis_tready_o,
  output logic [31:0]      m_axis_tdata_o,
  output logic             m_axis_tvalid_o,
  output logic             m_axis_tlast_o,
  input  logic             m_axis_tready_i,
  input  logic             rx_ack_vld_i,
  input  logic [SEQ_W-1:0] rx_ack_seq_i
);

  logic [SEQ_W-1:0] next_seq;
  logic [SEQ_W-1:0] outstanding;
  logic [SEQ_W-1:0] seq_after;
  logic [31:0]      hdr_beat;
  logic             in_pkt;
  logic             hdr_pending;
  logic             active;
  logic             window_open;
  logic             tlp_start;
  logic             tlp_done;

  assign active      = (link_status_i == DL_ACTIVE);
  assign window_open = outstanding < SEQ_W'(RETRY_TLP_SIZE);

  // New TLP only at a packet boundary with room in the window
  assign tlp_start = active && window_open && !in_pkt && s_axis_tvalid_i;
  assign s_axis_tready_o = active && window_open && in_pkt && !hdr_pending
                           && m_axis_tready_i;
  assign tlp_done  = s_axis_tvalid_i && s_axis_tready_o && s_axis_tlast_i;
  assign seq_after = next_seq + SEQ_W'(tlp_done);

  assign hdr_beat = {PKT_TLP_HDR, {(TYPE_LSB - SEQ_W){1'b0}}, next_seq};

  assign m_axis_tdata_o  = hdr_pending ? hdr_beat : s_axis_tdata_i;
  assign m_axis_tvalid_o = hdr_pending || (in_pkt && s_axis_tvalid_i);
  assign m_axis_tlast_o  = !hdr_pending && s_axis_tlast_i;

  always_ff @(posedge clk_i) begin
    if (reset_i || soft_reset_i) begin
      next_seq    <= '0;
      outstanding <= '0;
      in_pkt      <= 1'b0;
      hdr_pending <= 1'b0;
    end else begin
      if (tlp_start) begin
        in_pkt      <= 1'b1;
        hdr_pending <= 1'b1;
      end else if (hdr_pending && m_axis_tready_i) begin
        hdr_pending <= 1'b0;
      end
      if (tlp_done) begin
        in_pkt <= 1'b0;
      end
      next_seq <= seq_after;
      // Ack and Nak both release everything up to and including n
      if (rx_ack_vld_i) begin
        outstanding <= seq_after - rx_ack_seq_i - SEQ_W'(1);
      end else if (tlp_done) begin
        outstanding <= outstanding + SEQ_W'(1);
      end
    end
  end

endmodule

//--- src/pcie_datalink_init.sv
`timescale 1ns/10ps

module pcie_datalink_init
  import pcie_datalink_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            phy_link_up_i,
  input  logic            rx_initfc1_i,
  input  logic            rx_initfc2_i,
  output pcie_dl_status_e link_status_o,
  output logic            initfc_req_o,
  output dllp_req_e       initfc_req_type_o,
  output logic            soft_reset_o,
  output logic            dl_up_o
);

  pcie_dl_status_e state_q;
  pcie_dl_status_e state_d;

  always_comb begin
    state_d = state_q;
    if (!phy_link_up_i) begin
      state_d = DL_INACTIVE;
    end else begin
      case (state_q)
        DL_INACTIVE: begin
          state_d = DL_INIT1;
        end
        DL_INIT1: begin
          if (rx_initfc1_i) begin
            state_d = DL_INIT2;
          end
        end
        DL_INIT2: begin
          if (rx_initfc2_i) begin
            state_d = DL_ACTIVE;
          end
        end
        default: begin
          state_d = DL_ACTIVE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q           <= DL_INACTIVE;
      initfc_req_o      <= 1'b0;
      initfc_req_type_o <= REQ_NONE;
      soft_reset_o      <= 1'b0;
      dl_up_o           <= 1'b0;
    end else begin
      state_q      <= state_d;
      initfc_req_o <= 1'b0;
      // One pulse on link loss clears sequence state downstream
      soft_reset_o <= !phy_link_up_i && (state_q != DL_INACTIVE);
      dl_up_o      <= (state_d == DL_ACTIVE);
      // One InitFC request on entry to each init state
      if ((state_d == DL_INIT1) && (state_q != DL_INIT1)) begin
        initfc_req_o      <= 1'b1;
        initfc_req_type_o <= REQ_INITFC1;
      end else if ((state_d == DL_INIT2) && (state_q != DL_INIT2)) begin
        initfc_req_o      <= 1'b1;
        initfc_req_type_o <= REQ_INITFC2;
      end
    end
  end

  assign link_status_o = state_q;

endmodule

//--- src/pcie_datalink_layer.sv
`timescale 1ns/10ps

module pcie_datalink_layer
  import pcie_dllp_pkg::*;
  import pcie_datalink_pkg::*;
#(
  parameter int               RETRY_TLP_SIZE = 3,
  parameter logic [SEQ_W-1:0] RX_HDR_CREDITS = 12'd32
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] s_axis_tlp_tdata_i,
  input  logic        s_axis_tlp_tvalid_i,
  input  logic        s_axis_tlp_tlast_i,
  output logic        s_axis_tlp_tready_o,
  output logic [31:0] m_axis_tlp_tdata_o,
  output logic        m_axis_tlp_tvalid_o,
  output logic        m_axis_tlp_tlast_o,
  input  logic        m_axis_tlp_tready_i,
  input  logic [31:0] s_axis_phy_tdata_i,
  input  logic        s_axis_phy_tvalid_i,
  input  logic        s_axis_phy_tlast_i,
  output logic        s_axis_phy_tready_o,
  output logic [31:0] m_axis_phy_tdata_o,
  output logic        m_axis_phy_tvalid_o,
  output logic        m_axis_phy_tlast_o,
  input  logic        m_axis_phy_tready_i,
  input  logic        phy_link_up_i,
  output logic        dl_up_o
);

  pcie_dl_status_e  link_status;
  logic             soft_reset;
  logic             rx_initfc1;
  logic             rx_initfc2;
  logic             initfc_req;
  dllp_req_e        initfc_req_type;
  logic             ack_req;
  dllp_req_e        ack_req_type;
  logic [SEQ_W-1:0] ack_req_seq;
  logic             rx_ack_vld;
  logic [SEQ_W-1:0] rx_ack_seq;
  logic [31:0]      tlp_tdata;
  logic             tlp_tvalid;
  logic             tlp_tlast;
  logic             tlp_tready;

  pcie_datalink_init pcie_datalink_init_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .phy_link_up_i     (phy_link_up_i),
    .rx_initfc1_i      (rx_initfc1),
    .rx_initfc2_i      (rx_initfc2),
    .link_status_o     (link_status),
    .initfc_req_o      (initfc_req),
    .initfc_req_type_o (initfc_req_type),
    .soft_reset_o      (soft_reset),
    .dl_up_o           (dl_up_o)
  );

  dllp_receive dllp_receive_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .soft_reset_i    (soft_reset),
    .link_status_i   (link_status),
    .s_axis_tdata_i  (s_axis_phy_tdata_i),
    .s_axis_tvalid_i (s_axis_phy_tvalid_i),
    .s_axis_tlast_i  (s_axis_phy_tlast_i),
    .s_axis_tready_o (s_axis_phy_tready_o),
    .m_axis_tdata_o  (m_axis_tlp_tdata_o),
    .m_axis_tvalid_o (m_axis_tlp_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlp_tlast_o),
    .m_axis_tready_i (m_axis_tlp_tready_i),
    .rx_initfc1_o    (rx_initfc1),
    .rx_initfc2_o    (rx_initfc2),
    .rx_ack_vld_o    (rx_ack_vld),
    .rx_ack_seq_o    (rx_ack_seq),
    .ack_req_o       (ack_req),
    .ack_req_type_o  (ack_req_type),
    .ack_req_seq_o   (ack_req_seq)
  );

  dllp_transmit #(
    .RETRY_TLP_SIZE (RETRY_TLP_SIZE)
  ) dllp_transmit_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .soft_reset_i    (soft_reset),
    .link_status_i   (link_status),
    .s_axis_tdata_i  (s_axis_tlp_tdata_i),
    .s_axis_tvalid_i (s_axis_tlp_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlp_tlast_i),
    .s_axis_tready_o (s_axis_tlp_tready_o),
    .m_axis_tdata_o  (tlp_tdata),
    .m_axis_tvalid_o (tlp_tvalid),
    .m_axis_tlast_o  (tlp_tlast),
    .m_axis_tready_i (tlp_tready),
    .rx_ack_vld_i    (rx_ack_vld),
    .rx_ack_seq_i    (rx_ack_seq)
  );

  phy_tx_arbiter #(
    .RX_HDR_CREDITS (RX_HDR_CREDITS)
  ) phy_tx_arbiter_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .ack_req_i         (ack_req),
    .ack_req_type_i    (ack_req_type),
    .ack_req_seq_i     (ack_req_seq),
    .initfc_req_i      (initfc_req),
    .initfc_req_type_i (initfc_req_type),
    .tlp_tdata_i       (tlp_tdata),
    .tlp_tvalid_i      (tlp_tvalid),
    .tlp_tlast_i       (tlp_tlast),
    .tlp_tready_o      (tlp_tready),
    .m_axis_tdata_o    (m_axis_phy_tdata_o),
    .m_axis_tvalid_o   (m_axis_phy_tvalid_o),
    .m_axis_tlast_o    (m_axis_phy_tlast_o),
    .m_axis_tready_i   (m_axis_phy_tready_i)
  );

endmodule

//--- src/pcie_datalink_pkg.sv
package pcie_datalink_pkg;

  // Data link control state, as seen by the rest of the layer
  typedef enum logic [1:0] {
    DL_INACTIVE,
    DL_INIT1,
    DL_INIT2,
    DL_ACTIVE
  } pcie_dl_status_e;

  // DLLP request opcodes towards the output arbiter
  typedef enum logic [2:0] {
    REQ_NONE,
    REQ_ACK,
    REQ_NAK,
    REQ_INITFC1,
    REQ_INITFC2
  } dllp_req_e;

endpackage

//--- src/pcie_dllp_pkg.sv
package pcie_dllp_pkg;

  // Sequence number width, also the width of the credit field
  localparam int SEQ_W = 12;

  // Type field sits in the top byte of every beat
  localparam int TYPE_W   = 8;
  localparam int TYPE_LSB = 24;

  // Bits between the type field and the sequence field are zero
  // Values in bits 31:24 of a PHY beat
  typedef enum logic [TYPE_W-1:0] {
    DLLP_ACK     = 8'h00,
    DLLP_NAK     = 8'h10,
    DLLP_INITFC1 = 8'h40,
    DLLP_INITFC2 = 8'hC0,
    // Header beat in front of a TLP payload
    PKT_TLP_HDR  = 8'hF0
  } dllp_type_e;

endpackage

//--- src/phy_tx_arbiter.sv
`timescale 1ns/10ps

module phy_tx_arbiter
  import pcie_dllp_pkg::*;
  import pcie_datalink_pkg::*;
#(
  parameter logic [SEQ_W-1:0] RX_HDR_CREDITS = 12'd32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             ack_req_i,
  input  dllp_req_e        ack_req_type_i,
  input  logic [SEQ_W-1:0] ack_req_seq_i,
  input  logic             initfc_req_i,
  input  dllp_req_e        initfc_req_type_i,
  input  logic [31:0]      tlp_tdata_i,
  input  logic             tlp_tvalid_i,
  input  logic             tlp_tlast_i,
  output logic             tlp_tready_o,
  output logic [31:0]      m_axis_tdata_o,
  output logic             m_axis_tvalid_o,
  output logic             m_axis_tlast_o,
  input  logic             m_axis_tready_i
);

  typedef enum logic [1:0] {SEL_NONE, SEL_DLLP, SEL_TLP} sel_state_e;

  sel_state_e       sel;
  dllp_req_e        initfc_slot;
  dllp_req_e        acknak_slot;
  logic [SEQ_W-1:0] acknak_seq;
  logic [31:0]      dllp_beat;
  logic             load_initfc;
  logic             load_acknak;

  function automatic dllp_type_e req_code(dllp_req_e req);
    case (req)
      REQ_NAK:     return DLLP_NAK;
      REQ_INITFC1: return DLLP_INITFC1;
      REQ_INITFC2: return DLLP_INITFC2;
      default:     return DLLP_ACK;
    endcase
  endfunction

  // InitFC first, then Ack/Nak, only between packets
  assign load_initfc = (sel == SEL_NONE) && (initfc_slot != REQ_NONE);
  assign load_acknak = (sel == SEL_NONE) && (initfc_slot == REQ_NONE)
                       && (acknak_slot != REQ_NONE);

  assign tlp_tready_o = (sel == SEL_TLP) && m_axis_tready_i;

  always_comb begin
    case (sel)
      SEL_DLLP: begin
        m_axis_tdata_o  = dllp_beat;
        m_axis_tvalid_o = 1'b1;
        m_axis_tlast_o  = 1'b1;
      end
      SEL_TLP: begin
        m_axis_tdata_o  = tlp_tdata_i;
        m_axis_tvalid_o = tlp_tvalid_i;
        m_axis_tlast_o  = tlp_tlast_i;
      end
      default: begin
        m_axis_tdata_o  = dllp_beat;
        m_axis_tvalid_o = 1'b0;
        m_axis_tlast_o  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel         <= SEL_NONE;
      initfc_slot <= REQ_NONE;
      acknak_slot <= REQ_NONE;
    end else begin
      if (load_initfc) begin
        initfc_slot <= REQ_NONE;
      end
      if (initfc_req_i) begin
        initfc_slot <= initfc_req_type_i;
      end
      if (load_acknak) begin
        acknak_slot <= REQ_NONE;
      end
      // Newer Ack/Nak replaces an older one still waiting
      if (ack_req_i) begin
        acknak_slot <= ack_req_type_i;
      end
      case (sel)
        SEL_NONE: begin
          if (load_initfc || load_acknak) begin
            sel <= SEL_DLLP;
          end else if (tlp_tvalid_i) begin
            sel <= SEL_TLP;
          end
        end
        SEL_DLLP: begin
          if (m_axis_tready_i) begin
            sel <= SEL_NONE;
          end
        end
        SEL_TLP: begin
          if (tlp_tvalid_i && m_axis_tready_i && tlp_tlast_i) begin
            sel <= SEL_NONE;
          end
        end
        default: begin
          sel <= SEL_NONE;
        end
      endcase
    end
  end

  // Beat is built once and held until the PHY takes it
  always_ff @(posedge clk_i) begin
    if (ack_req_i) begin
      acknak_seq <= ack_req_seq_i;
    end
    if (load_initfc) begin
      dllp_beat <= {req_code(initfc_slot), {(TYPE_LSB - SEQ_W){1'b0}}, RX_HDR_CREDITS};
    end else if (load_acknak) begin
      dllp_beat <= {req_code(acknak_slot), {(TYPE_LSB - SEQ_W){1'b0}}, acknak_seq};
    end
  end

endmodule

//--- verif/pcie_datalink_layer_props.sv
`timescale 1ns/10ps

module pcie_datalink_layer_props (
  input logic        clk_i,
  input logic        reset_i,
  input logic [31:0] phy_tdata_i,
  input logic        phy_tvalid_i,
  input logic        phy_tready_i,
  input logic        phy_link_up_i,
  input logic        dl_up_i,
  input logic        tlp_tvalid_i
);

  // Stalled PHY beat must hold its data
  phy_data_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (phy_tvalid_i && !phy_tready_i) |=> $stable(phy_tdata_i))
    else $error("PHY output data changed while the beat was stalled");

  // Link loss takes the data link down on the next cycle
  link_loss_drops_dl_up: assert property (@(posedge clk_i) disable iff (reset_i)
    !phy_link_up_i |=> !dl_up_i)
    else $error("dl_up_o stayed high after the physical link went down");

  user_quiet_when_down: assert property (@(posedge clk_i) disable iff (reset_i)
    !dl_up_i |-> !tlp_tvalid_i)
    else $error("User TLP output was valid while the data link was down");

endmodule

bind pcie_datalink_layer pcie_datalink_layer_props pcie_datalink_layer_props_inst (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .phy_tdata_i   (m_axis_phy_tdata_o),
  .phy_tvalid_i  (m_axis_phy_tvalid_o),
  .phy_tready_i  (m_axis_phy_tready_i),
  .phy_link_up_i (phy_link_up_i),
  .dl_up_i       (dl_up_o),
  .tlp_tvalid_i  (m_axis_tlp_tvalid_o)
);

//--- verif/pcie_datalink_layer_tb.sv
`timescale 1ns/10ps

module pcie_datalink_layer_tb
  import pcie_dllp_pkg::*;
();

  localparam int               RETRY     = 3;
  localparam logic [SEQ_W-1:0] CREDITS   = 12'd32;
  localparam logic [31:0]      SEED      = 32'h03b3f330;
  localparam int               MAX_BEATS = 150;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] s_axis_tlp_tdata_i;
  logic        s_axis_tlp_tvalid_i;
  logic        s_axis_tlp_tlast_i;
  logic        s_axis_tlp_tready_o;
  logic [31:0] m_axis_tlp_tdata_o;
  logic        m_axis_tlp_tvalid_o;
  logic        m_axis_tlp_tlast_o;
  logic        m_axis_tlp_tready_i;
  logic [31:0] s_axis_phy_tdata_i;
  logic        s_axis_phy_tvalid_i;
  logic        s_axis_phy_tlast_i;
  logic        s_axis_phy_tready_o;
  logic [31:0] m_axis_phy_tdata_o;
  logic        m_axis_phy_tvalid_o;
  logic        m_axis_phy_tlast_o;
  logic        m_axis_phy_tready_i;
  logic        phy_link_up_i;
  logic        dl_up_o;

  // Queued beats hold {last, data}
  logic [32:0]      exp_phy[$];
  logic [32:0]      exp_usr[$];
  logic [32:0]      got_phy[$];
  logic [32:0]      got_usr[$];
  logic [31:0]      data_state;
  logic [31:0]      ready_state;
  logic [SEQ_W-1:0] tx_seq;
  logic [SEQ_W-1:0] rx_exp;
  int               phy_errors;
  int               usr_errors;
  int               chk_errors;

  pcie_datalink_layer #(
    .RETRY_TLP_SIZE (RETRY),
    .RX_HDR_CREDITS (CREDITS)
  ) pcie_datalink_layer_inst (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    data_state = xorshift(data_state);
    return data_state;
  endfunction

  // Reference model of one PHY output beat
  function automatic logic [32:0] expected_phy_beat(input bit payload_beat,
      input dllp_type_e kind, input logic [SEQ_W-1:0] field, input logic [31:0] data,
      input bit last);
    if (payload_beat) begin
      return {last, data};
    end else if (kind == PKT_TLP_HDR) begin
      return {1'b0, kind, 12'h000, field};
    end
    return {1'b1, kind, 12'h000, field};
  endfunction

  always @(posedge clk_i) begin
    #1;
    ready_state = xorshift(ready_state);
    m_axis_phy_tready_i = (ready_state[1:0] != 2'b00);
    m_axis_tlp_tready_i = (ready_state[3:2] != 2'b00);
  end

  // Sampled mid-cycle, where the handshake signals are settled
  always @(negedge clk_i) begin
    if (!reset_i && m_axis_phy_tvalid_o && m_axis_phy_tready_i) begin
      got_phy.push_back({m_axis_phy_tlast_o, m_axis_phy_tdata_o});
    end
    if (!reset_i && m_axis_tlp_tvalid_o && m_axis_tlp_tready_i) begin
      got_usr.push_back({m_axis_tlp_tlast_o, m_axis_tlp_tdata_o});
    end
  end

  always @(posedge clk_i) begin : compare
    logic [32:0] g;
    logic [32:0] e;
    while (got_phy.size() > 0) begin
      g = got_phy.pop_front();
      assert (exp_phy.size() > 0) else begin
        $display("** Error at %0t: PHY beat %h arrived with none expected", $time, g);
        phy_errors++;
      end
      if (exp_phy.size() > 0) begin
        e = exp_phy.pop_front();
        assert (g == e) else begin
          $display("** Error at %0t: PHY beat %h, expected %h", $time, g, e);
          phy_errors++;
        end
      end
    end
    while (got_usr.size() > 0) begin
      g = got_usr.pop_front();
      assert (exp_usr.size() > 0) else begin
        $display("** Error at %0t: user beat %h arrived with none expected", $time, g);
        usr_errors++;
      end
      if (exp_usr.size() > 0) begin
        e = exp_usr.pop_front();
        assert (g == e) else begin
          $display("** Error at %0t: user beat %h, expected %h", $time, g, e);
          usr_errors++;
        end
      end
    end
  end

  task automatic wait_drain();
    while (exp_phy.size() > 0 || exp_usr.size() > 0) begin
      @(posedge clk_i);
      #1;
    end
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  task automatic send_phy_beat(input logic [31:0] data, input bit last);
    bit ok;
    ok = 1'b0;
    s_axis_phy_tdata_i  = data;
    s_axis_phy_tlast_i  = last;
    s_axis_phy_tvalid_i = 1'b1;
    while (!ok) begin
      @(negedge clk_i);
      ok = s_axis_phy_tready_o;
      @(posedge clk_i);
      #1;
    end
    s_axis_phy_tvalid_i = 1'b0;
    s_axis_phy_tlast_i  = 1'b0;
  endtask

  task automatic send_dllp(input dllp_type_e kind, input logic [SEQ_W-1:0] field);
    send_phy_beat({kind, 12'h000, field}, 1'b1);
  endtask

  // Gives up only if the first beat is refused for limit cycles
  task automatic send_tlp(input int len, input int limit, output bit accepted);
    logic [31:0] beats[4];
    int          waited;
    bit          ok;
    for (int i = 0; i < len; i++) begin
      beats[i] = next_rand();
    end
    exp_phy.push_back(expected_phy_beat(1'b0, PKT_TLP_HDR, tx_seq, 32'h0, 1'b0));
    for (int i = 0; i < len; i++) begin
      exp_phy.push_back(expected_phy_beat(1'b1, PKT_TLP_HDR, 12'h000, beats[i], i == len - 1));
    end
    accepted = 1'b1;
    for (int i = 0; i < len; i++) begin
      s_axis_tlp_tdata_i  = beats[i];
      s_axis_tlp_tlast_i  = (i == len - 1);
      s_axis_tlp_tvalid_i = 1'b1;
      waited = 0;
      ok = 1'b0;
      while (!ok && !(i == 0 && waited >= limit)) begin
        @(negedge clk_i);
        ok = s_axis_tlp_tready_o;
        @(posedge clk_i);
        #1;
        waited++;
      end
      if (!ok) begin
        s_axis_tlp_tvalid_i = 1'b0;
        s_axis_tlp_tlast_i  = 1'b0;
        for (int j = 0; j <= len; j++) begin
          void'(exp_phy.pop_back());
        end
        accepted = 1'b0;
        return;
      end
    end
    s_axis_tlp_tvalid_i = 1'b0;
    s_axis_tlp_tlast_i  = 1'b0;
    tx_seq = tx_seq + 12'd1;
  endtask

  task automatic feed_tlp(input logic [SEQ_W-1:0] seq, input int len, input bit good);
    logic [31:0] beats[4];
    for (int i = 0; i < len; i++) begin
      beats[i] = next_rand();
      if (good) begin
        exp_usr.push_back({i == len - 1, beats[i]});
      end
    end
    send_phy_beat({PKT_TLP_HDR, 12'h000, seq}, 1'b0);
    for (int i = 0; i < len; i++) begin
      send_phy_beat(beats[i], i == len - 1);
    end
  endtask

  task automatic link_init();
    exp_phy.push_back(expected_phy_beat(1'b0, DLLP_INITFC1, CREDITS, 32'h0, 1'b1));
    phy_link_up_i = 1'b1;
    wait_drain();
    exp_phy.push_back(expected_phy_beat(1'b0, DLLP_INITFC2, CREDITS, 32'h0, 1'b1));
    send_dllp(DLLP_INITFC1, CREDITS);
    wait_drain();
    send_dllp(DLLP_INITFC2, CREDITS);
    while (!dl_up_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    repeat (200 * MAX_BEATS + 2000) @(posedge clk_i);
    $display("Timeout: the run did not finish in the expected time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : stimulus
    bit               acc;
    int               count;
    logic [SEQ_W-1:0] w0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    s_axis_tlp_tdata_i = '0;
    s_axis_tlp_tvalid_i = 1'b0;
    s_axis_tlp_tlast_i = 1'b0;
    m_axis_tlp_tready_i = 1'b1;
    s_axis_phy_tdata_i = '0;
    s_axis_phy_tvalid_i = 1'b0;
    s_axis_phy_tlast_i = 1'b0;
    m_axis_phy_tready_i = 1'b0;
    phy_link_up_i = 1'b0;
    data_state = SEED;
    ready_state = xorshift(xorshift(SEED));
    tx_seq = '0;
    rx_exp = '0;
    phy_errors = 0;
    usr_errors = 0;
    chk_errors = 0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Reset state, and silence while the link is down
    assert (!m_axis_phy_tvalid_o && !m_axis_tlp_tvalid_o && !s_axis_tlp_tready_o && !dl_up_o)
      else begin
        $display("Control outputs were not all low after reset");
        chk_errors++;
      end
    repeat (10) @(posedge clk_i);
    #1;

    link_init();

    for (int t = 0; t < 6; t++) begin
      send_tlp(1 + int'(next_rand() % 32'd4), 1000, acc);
      assert (acc) else begin
        $display("A TLP was refused while the window was open");
        chk_errors++;
      end
      wait_drain();
      send_dllp(DLLP_ACK, tx_seq - 12'd1);
    end

    // Window fills without Acks
    w0 = tx_seq;
    count = 0;
    acc = 1'b1;
    while (acc && count < RETRY + 2) begin
      send_tlp(1 + int'(next_rand() % 32'd4), 40, acc);
      if (acc) begin
        count++;
        wait_drain();
      end
    end
    assert (count == RETRY) else begin
      $display("Window accepted %0d TLPs instead of %0d", count, RETRY);
      chk_errors++;
    end
    send_dllp(DLLP_ACK, w0);
    count = 0;
    acc = 1'b1;
    while (acc && count < 3) begin
      send_tlp(1 + int'(next_rand() % 32'd4), 40, acc);
      if (acc) begin
        count++;
        wait_drain();
      end
    end
    assert (count == 1) else begin
      $display("One Ack released %0d TLPs instead of one", count);
      chk_errors++;
    end
    send_dllp(DLLP_ACK, tx_seq - 12'd1);

    exp_phy.push_back(expected_phy_beat(1'b0, DLLP_ACK, rx_exp, 32'h0, 1'b1));
    feed_tlp(rx_exp, 1 + int'(next_rand() % 32'd4), 1'b1);
    rx_exp = rx_exp + 12'd1;
    wait_drain();
    exp_phy.push_back(expected_phy_beat(1'b0, DLLP_NAK, rx_exp - 12'd1, 32'h0, 1'b1));
    feed_tlp(rx_exp + 12'd7, 1 + int'(next_rand() % 32'd4), 1'b0);
    wait_drain();

    // Link loss and restart from sequence 0
    phy_link_up_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    assert (!dl_up_o) else begin
      $display("dl_up_o stayed high after the link went down");
      chk_errors++;
    end
    tx_seq = '0;
    rx_exp = '0;
    link_init();
    send_tlp(1 + int'(next_rand() % 32'd4), 1000, acc);
    assert (acc) else begin
      $display("A TLP was refused after the link came back");
      chk_errors++;
    end
    wait_drain();
    send_dllp(DLLP_ACK, tx_seq - 12'd1);
    repeat (4) @(posedge clk_i);

    $display("Errors: phy %0d, user %0d, checks %0d", phy_errors, usr_errors, chk_errors);
    if (phy_errors + usr_errors + chk_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
